// File: Bender.yml
package:
  name: aes256_enc

sources:
  # RTL, package first
  - hw/aes_enc_pkg.sv
  - hw/aes_sbox_rom.sv
  - hw/aes_byte_serializer.sv
  - hw/aes_shift_rows.sv
  - hw/aes_mix_columns.sv
  - hw/aes256_enc.sv
  # Testbench and bound checker
  - target: test
    files:
      - verification/aes256_enc_assert.sv
      - verification/aes256_enc_tb.sv

// File: hw/aes256_enc.sv
module aes256_enc (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    start,
    input  aes_enc_pkg::block_t     din,
    input  aes_enc_pkg::round_key_t round_key,
    output aes_enc_pkg::key_addr_t  key_addr,
    output aes_enc_pkg::block_t     dout,
    output logic                    done
);

    import aes_enc_pkg::*;

    enc_state_e state_q;
    enc_state_e state_d;
    round_t     round;
    byte_cnt_t  sub_cnt;

    // Datapath
    state_t din_state;
    state_t key_state;
    state_t in_state;
    state_t ark_in;
    state_t ark_out;
    state_t ark_reg;
    state_t sr_state;
    state_t mc_state;
    byte_t  ser_byte;
    byte_t  sbox_byte;

    // Strobes toward the round blocks
    logic load;
    logic step;
    logic step_d;
    logic shift_en;
    logic capture;
    logic bypass;

    // Block and key bytes, byte i from bits 8i+7:8i
    always_comb
    begin
        for (int i = 0; i < BLOCK_BYTES; i++)
        begin
            din_state[i] = din[BYTE_W*i +: BYTE_W];
            key_state[i] = round_key[BYTE_W*i +: BYTE_W];
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state_q <= idle;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            idle:
                if (start)
                    state_d = add_key;
            add_key:   state_d = load_sub;
            load_sub:  state_d = sub_bytes;
            // One S-box lookup per cycle
            sub_bytes:
                if (sub_cnt == byte_cnt_t'(BLOCK_BYTES - 1))
                    state_d = sub_wait;
            // Last ROM byte still in flight
            sub_wait:  state_d = shift;
            shift:     state_d = mix;
            mix:       state_d = end_round;
            end_round: state_d = (round == round_t'(NUM_ROUNDS)) ? finish : add_key;
            finish:    state_d = idle;
            default:   state_d = idle;
        endcase
    end

    assign load     = (state_q == load_sub);
    assign step     = (state_q == sub_bytes);
    assign shift_en = (state_q == shift);
    assign capture  = (state_q == mix);
    // No MixColumns in round 14
    assign bypass   = (round == round_t'(NUM_ROUNDS));

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            sub_cnt  <= '0;
            step_d   <= 1'b0;
            round    <= '0;
            key_addr <= '0;
        end
        else
        begin
            // Matches the S-box latency
            step_d <= step;
            if (state_q == sub_bytes)
                sub_cnt <= sub_cnt + 1'b1;
            else
                sub_cnt <= '0;
            // Round counts passes, key address counts finished rounds
            if (state_q == idle)
            begin
                round    <= '0;
                key_addr <= '0;
            end
            else
            begin
                if (state_q == add_key)
                    round <= round + 1'b1;
                if (state_q == end_round)
                    key_addr <= key_addr + 1'b1;
            end
        end
    end

    // Plaintext only taken when idle
    always_ff @(posedge clk)
    begin
        if (state_q == idle && start)
            in_state <= din_state;
    end

    // AddRoundKey, first key on the plaintext, then on the loopback
    assign ark_in  = (round == '0) ? in_state : mc_state;
    assign ark_out = ark_in ^ key_state;

    always_ff @(posedge clk)
    begin
        if (state_q == add_key)
            ark_reg <= ark_out;
    end

    // Final key 14 goes straight to the output
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            dout <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= (state_q == finish);
            if (state_q == finish)
            begin
                for (int i = 0; i < BLOCK_BYTES; i++)
                    dout[BYTE_W*i +: BYTE_W] <= ark_out[i];
            end
        end
    end

    aes_byte_serializer u_serializer (
        .clk      (clk),
        .resetn   (resetn),
        .load     (load),
        .state    (ark_reg),
        .step     (step),
        .byte_out (ser_byte)
    );

    aes_sbox_rom u_sbox (
        .clk    (clk),
        .resetn (resetn),
        .addr   (ser_byte),
        .data   (sbox_byte)
    );

    aes_shift_rows u_shift_rows (
        .clk        (clk),
        .resetn     (resetn),
        .byte_valid (step_d),
        .sub_byte   (sbox_byte),
        .shift_en   (shift_en),
        .state      (sr_state)
    );

    aes_mix_columns u_mix_columns (
        .clk      (clk),
        .resetn   (resetn),
        .capture  (capture),
        .bypass   (bypass),
        .state_in (sr_state),
        .state    (mc_state)
    );

endmodule

// File: hw/aes_byte_serializer.sv
module aes_byte_serializer (
    input  logic                clk,
    input  logic                resetn,
    input  logic                load,
    input  aes_enc_pkg::state_t state,
    input  logic                step,
    output aes_enc_pkg::byte_t  byte_out
);

    import aes_enc_pkg::*;

    state_t    hold_q;
    byte_cnt_t ptr;

    // Snapshot of the round state
    always_ff @(posedge clk)
    begin
        if (load)
            hold_q <= state;
    end

    // Read pointer, restarts at byte 0 on every load
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            ptr <= '0;
        else if (load)
            ptr <= '0;
        else if (step)
            ptr <= ptr + 1'b1;
    end

    // Current byte goes straight to the S-box address
    assign byte_out = hold_q[ptr];

endmodule

// File: hw/aes_enc_pkg.sv
package aes_enc_pkg;

    // Byte and block geometry
    localparam int BYTE_W      = 8;
    localparam int BLOCK_BYTES = 16;
    localparam int BLOCK_W     = BLOCK_BYTES * BYTE_W;

    // State is column-major, four rows per column
    localparam int NUM_ROWS    = 4;
    localparam int NUM_COLS    = BLOCK_BYTES / NUM_ROWS;

    // AES-256 runs 14 full rounds, key addresses 0 to 14
    localparam int NUM_ROUNDS  = 14;
    localparam int CNT_W       = 4;

    typedef logic [BYTE_W-1:0]  byte_t;
    typedef logic [BLOCK_W-1:0] block_t;
    // Byte 4c+r holds row r of column c
    typedef byte_t [BLOCK_BYTES-1:0] state_t;
    typedef logic [BLOCK_W-1:0] round_key_t;
    typedef logic [CNT_W-1:0]   key_addr_t;
    typedef logic [CNT_W-1:0]   round_t;
    typedef logic [CNT_W-1:0]   byte_cnt_t;

    // Round controller states
    typedef enum logic [3:0] {
        idle,
        add_key,
        load_sub,
        sub_bytes,
        sub_wait,
        shift,
        mix,
        end_round,
        finish
    } enc_state_e;

endpackage

// File: hw/aes_mix_columns.sv
module aes_mix_columns (
    input  logic                clk,
    input  logic                resetn,
    input  logic                capture,
    input  logic                bypass,
    input  aes_enc_pkg::state_t state_in,
    output aes_enc_pkg::state_t state
);

    import aes_enc_pkg::*;

    state_t mixed;

    // Multiply by 2 in GF(2^8), reduction polynomial 0x11b
    function automatic byte_t xtime(input byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // One output byte, 2*a0 ^ 3*a1 ^ a2 ^ a3
    function automatic byte_t mix_byte(
        input byte_t a0,
        input byte_t a1,
        input byte_t a2,
        input byte_t a3
    );
        return xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
    endfunction

    // Each row uses the column rotated so that its own byte comes first
    always_comb
    begin
        for (int c = 0; c < NUM_COLS; c++)
        begin
            for (int r = 0; r < NUM_ROWS; r++)
            begin
                mixed[NUM_ROWS*c + r] = mix_byte(
                    state_in[NUM_ROWS*c + r],
                    state_in[NUM_ROWS*c + (r + 1) % NUM_ROWS],
                    state_in[NUM_ROWS*c + (r + 2) % NUM_ROWS],
                    state_in[NUM_ROWS*c + (r + 3) % NUM_ROWS]
                );
            end
        end
    end

    // Loopback register, last round skips the mix
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= '0;
        end
        else if (capture)
        begin
            state <= bypass ? state_in : mixed;
        end
    end

endmodule

// File: hw/aes_sbox_rom.sv
module aes_sbox_rom (
    input  logic               clk,
    input  logic               resetn,
    input  aes_enc_pkg::byte_t addr,
    output aes_enc_pkg::byte_t data
);

    import aes_enc_pkg::*;

    // One S-box row of 16 entries, entry 0 in the top byte
    logic [BLOCK_W-1:0] row;

    // Row picked by the high nibble
    always_comb
    begin
        case (addr[7:4])
            4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
            4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
            4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
            4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
            4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
            4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
            4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
            4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
            4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
            4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
            4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
            4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
            4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
            4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
            4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
            default: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
        endcase
    end

    // Low nibble selects the column, result one cycle later
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            data <= '0;
        end
        else
        begin
            data <= row[BYTE_W*(BLOCK_BYTES-1-addr[3:0]) +: BYTE_W];
        end
    end

endmodule

// File: hw/aes_shift_rows.sv
module aes_shift_rows (
    input  logic                clk,
    input  logic                resetn,
    input  logic                byte_valid,
    input  aes_enc_pkg::byte_t  sub_byte,
    input  logic                shift_en,
    output aes_enc_pkg::state_t state
);

    import aes_enc_pkg::*;

    state_t    gather;
    state_t    shifted;
    byte_cnt_t wr_idx;

    // Substituted bytes arrive in index order
    always_ff @(posedge clk)
    begin
        if (byte_valid)
            gather[wr_idx] <= sub_byte;
    end

    // Write index wraps after 16 bytes
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            wr_idx <= '0;
        else if (byte_valid)
            wr_idx <= wr_idx + 1'b1;
    end

    // Row r rotated left by r columns
    always_comb
    begin
        for (int c = 0; c < NUM_COLS; c++)
        begin
            for (int r = 0; r < NUM_ROWS; r++)
                shifted[NUM_ROWS*c + r] = gather[NUM_ROWS*((c + r) % NUM_COLS) + r];
        end
    end

    always_ff @(posedge clk)
    begin
        if (shift_en)
            state <= shifted;
    end

endmodule

// File: verification/aes256_enc_assert.sv
module aes256_enc_assert (
    input logic                   clk,
    input logic                   resetn,
    input logic                   start,
    input aes_enc_pkg::key_addr_t key_addr,
    input aes_enc_pkg::block_t    dout,
    input logic                   done
);

    import aes_enc_pkg::*;

    // Failures so far, polled by the testbench
    int   fail_count = 0;
    logic busy;
    logic reset_held = 1'b0;

    // Block in flight, start only taken when idle or on the done cycle
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            busy <= 1'b0;
        else if (start && (!busy || done))
            busy <= 1'b1;
        else if (done)
            busy <= 1'b0;
    end

    // Reset already low at the previous edge
    always @(posedge clk)
    begin
        reset_held <= !resetn;
    end

    // Reset drops done and the key address
    a_reset_clear: assert property (@(posedge clk)
        (!resetn && reset_held) |-> (key_addr == '0 && !done))
        else
        begin
            fail_count++;
            $error("key_addr or done not cleared while in reset");
        end

    // Key address rests at 0 outside a block
    a_key_idle: assert property (@(posedge clk) disable iff (!resetn)
        !busy |-> key_addr == '0)
        else
        begin
            fail_count++;
            $error("key_addr %0d outside a block", key_addr);
        end

    // Only +1 steps, or back to 0 right after done
    a_key_step: assert property (@(posedge clk) disable iff (!resetn)
        (key_addr != $past(key_addr)) |->
            (key_addr == key_addr_t'($past(key_addr) + 1'b1))
            || ($past(done) && key_addr == '0))
        else
        begin
            fail_count++;
            $error("key_addr jumped from %0d to %0d", $past(key_addr), key_addr);
        end

    // Never past the last round key
    a_key_range: assert property (@(posedge clk) disable iff (!resetn)
        key_addr <= key_addr_t'(NUM_ROUNDS))
        else
        begin
            fail_count++;
            $error("key_addr %0d above last round", key_addr);
        end

    // Done only inside a started block, with the last key selected
    a_done_key: assert property (@(posedge clk) disable iff (!resetn)
        done |-> (busy && key_addr == key_addr_t'(NUM_ROUNDS)))
        else
        begin
            fail_count++;
            $error("done without a block or with key_addr %0d", key_addr);
        end

    // Single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
        else
        begin
            fail_count++;
            $error("done high for two cycles");
        end

    // Output holds between done pulses
    a_dout_hold: assert property (@(posedge clk) disable iff (!resetn)
        !done |-> dout == $past(dout))
        else
        begin
            fail_count++;
            $error("dout changed without done");
        end

endmodule

// File: verification/aes256_enc_tb.sv
module aes256_enc_tb;

    import aes_enc_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int BLOCK_CYCLES = 400;
    localparam int NUM_BLOCKS   = 4;

    // FIPS-197 appendix C.3, first byte on the left
    localparam block_t PLAIN_FIPS  = 128'h00112233445566778899aabbccddeeff;
    localparam block_t CIPHER_FIPS = 128'h8ea2b7ca516745bfeafc49904b496089;

    logic       clk;
    logic       resetn;
    logic       start;
    block_t     din;
    round_key_t round_key;
    key_addr_t  key_addr;
    block_t     dout;
    logic       done;

    round_key_t key_mem [0:15];
    block_t     plain;
    block_t     expected;
    int         seed;
    int         spurious_gap;

    // First published byte goes to bits 7:0
    function automatic block_t to_block(input logic [BLOCK_W-1:0] fips);
        block_t b;
        for (int i = 0; i < BLOCK_BYTES; i++)
            b[BYTE_W*i +: BYTE_W] = fips[BYTE_W*(BLOCK_BYTES-1-i) +: BYTE_W];
        return b;
    endfunction

    // Expanded schedule of key 000102..1f
    task automatic load_key_table();
        key_mem[0]  = to_block(128'h000102030405060708090a0b0c0d0e0f);
        key_mem[1]  = to_block(128'h101112131415161718191a1b1c1d1e1f);
        key_mem[2]  = to_block(128'ha573c29fa176c498a97fce93a572c09c);
        key_mem[3]  = to_block(128'h1651a8cd0244beda1a5da4c10640bade);
        key_mem[4]  = to_block(128'hae87dff00ff11b68a68ed5fb03fc1567);
        key_mem[5]  = to_block(128'h6de1f1486fa54f9275f8eb5373b8518d);
        key_mem[6]  = to_block(128'hc656827fc9a799176f294cec6cd5598b);
        key_mem[7]  = to_block(128'h3de23a75524775e727bf9eb45407cf39);
        key_mem[8]  = to_block(128'h0bdc905fc27b0948ad5245a4c1871c2f);
        key_mem[9]  = to_block(128'h45f5a66017b2d387300d4d33640a820a);
        key_mem[10] = to_block(128'h7ccff71cbeb4fe5413e6bbf0d261a7df);
        key_mem[11] = to_block(128'hf01afafee7a82979d7a5644ab3afe640);
        key_mem[12] = to_block(128'h2541fe719bf500258813bbd55a721c0a);
        key_mem[13] = to_block(128'h4e5a6699a9f24fe07e572baacdf8cdea);
        key_mem[14] = to_block(128'h24fc79ccbf0979e9371ac23c6d68de36);
        // Unused address
        key_mem[15] = '0;
    endtask

    // Key memory answers combinationally
    assign round_key = key_mem[key_addr];

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    aes256_enc u_dut (
        .clk       (clk),
        .resetn    (resetn),
        .start     (start),
        .din       (din),
        .round_key (round_key),
        .key_addr  (key_addr),
        .dout      (dout),
        .done      (done)
    );

    bind aes256_enc aes256_enc_assert u_assert (
        .clk      (clk),
        .resetn   (resetn),
        .start    (start),
        .key_addr (key_addr),
        .dout     (dout),
        .done     (done)
    );

    task automatic pulse_reset(input int cycles);
        @(negedge clk);
        resetn = 1'b0;
        repeat (cycles) @(negedge clk);
        resetn = 1'b1;
    endtask

    // One-cycle start strobe with the block on din
    task automatic send_block(input block_t block);
        @(negedge clk);
        din   = block;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done)
            @(negedge clk);
    endtask

    task automatic check_dout(input block_t exp);
        if (dout !== exp)
        begin
            $display("ERROR: time %0t dout expected %h actual %h", $time, exp, dout);
            $display("TEST FAILED");
            $fatal(1, "dout mismatch");
        end
    endtask

    // Stop at the first failure of the bound checker
    always @(negedge clk)
    begin
        if (u_dut.u_assert.fail_count != 0)
        begin
            $display("a protocol assertion failed in the bound checker");
            $display("TEST FAILED");
            $fatal(1, "assertion failure");
        end
    end

    initial
    begin
        #(NUM_BLOCKS * BLOCK_CYCLES * CLK_PERIOD);
        $display("timeout: done never arrived");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        seed   = 71;
        resetn = 1'b0;
        start  = 1'b0;
        din    = '0;
        load_key_table();
        plain    = to_block(PLAIN_FIPS);
        expected = to_block(CIPHER_FIPS);
        repeat (2) @(negedge clk);
        resetn = 1'b1;

        // Known answer
        send_block(plain);
        wait_done();
        check_dout(expected);

        // Second block right after done
        send_block(plain);
        wait_done();
        check_dout(expected);

        // Stray start with other data somewhere inside the block
        spurious_gap = 20 + ({$random(seed)} % 250);
        send_block(plain);
        repeat (spurious_gap) @(negedge clk);
        din   = ~plain;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_done();
        check_dout(expected);
        // Quiet gap, a late extra done trips the checker
        repeat (40) @(negedge clk);

        // Abort a block by reset, then run a clean one
        send_block(plain);
        repeat (100) @(negedge clk);
        pulse_reset(2);
        send_block(plain);
        wait_done();
        check_dout(expected);

        repeat (4) @(negedge clk);
        if (u_dut.u_assert.fail_count == 0)
        begin
            $display("TEST PASSED");
            $finish;
        end
        else
        begin
            $display("TEST FAILED");
            $fatal(1, "assertion failures at end of run");
        end
    end

endmodule

// File: verilog.f
hw/aes_enc_pkg.sv
hw/aes_sbox_rom.sv
hw/aes_byte_serializer.sv
hw/aes_shift_rows.sv
hw/aes_mix_columns.sv
hw/aes256_enc.sv
verification/aes256_enc_assert.sv
verification/aes256_enc_tb.sv
